// File: list.f
source/rx_frame_pkg.sv
source/rx_frame_ifs.sv
source/link_arbiter.sv
source/frame_classifier.sv
source/frame_buffer.sv
source/frame_reader.sv
source/rx_frame_top.sv
tb/clock_gen.sv
tb/rx_frame_tb.sv

// File: run.sh
#!/bin/sh
# build the receive path testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f list.f --top-module rx_frame_tb \
    -o rx_frame_sim &&
./obj_dir/rx_frame_sim | tee /dev/stderr | grep -qF "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb/rx_frame_tb.sv
`timescale 1ns/1ps
// ------------------------------------------------
// testbench of the receive path: two link queue
// models, frame stimulus, expected words from a
// reference model and a compare on both outputs
// ------------------------------------------------
module rx_frame_tb;

    // frame rules, restated here for the reference model
    localparam int          hdr_len         = 14;
    localparam int          src_idx         = 3;
    localparam int          type_hi_idx     = 8;
    localparam int          type_lo_idx     = 9;
    localparam int          src_bit         = 2;
    localparam int          status_addr     = 118;
    localparam logic [15:0] cfg_frame_type  = 16'h0C01;
    localparam logic [15:0] data_frame_type = 16'h0D01;
    localparam logic [7:0]  good_src        = 8'h36;
    localparam logic [7:0]  bad_src         = 8'h32;

    logic        clk_100m;
    logic        rst_100m;
    logic        link1_empty = 1'b1;
    logic        link1_dval  = 1'b0;
    logic [17:0] link1_data  = '0;
    logic        link1_rdreq;
    logic        link2_empty = 1'b1;
    logic        link2_dval  = 1'b0;
    logic [17:0] link2_data  = '0;
    logic        link2_rdreq;
    logic        cfg_valid;
    logic [9:0]  cfg_data;
    logic        dt_valid;
    logic [9:0]  dt_data;

    // link queue contents and expected output words
    logic [17:0] link1_q [$];
    logic [17:0] link2_q [$];
    logic [9:0]  exp_cfg [$];
    logic [9:0]  exp_dt [$];

    // frame under construction
    logic [17:0] frame_words [0:255];
    int          frame_len;

    integer      seed = 56145;
    int          loaded_words = 0;
    int          mismatch_count = 0;
    int          unexpected_count = 0;
    int          missing_count = 0;
    int          protocol_count = 0;
    string       test_name = "reset";
    logic [9:0]  cfg_expect;
    logic [9:0]  dt_expect;

    clock_gen clock_gen_inst (
        .clk_100m (clk_100m),
        .rst_100m (rst_100m)
    );

    rx_frame_top rx_frame_top_inst (
        .clk_100m    (clk_100m),
        .rst_100m    (rst_100m),
        .link1_empty (link1_empty),
        .link1_dval  (link1_dval),
        .link1_data  (link1_data),
        .link1_rdreq (link1_rdreq),
        .link2_empty (link2_empty),
        .link2_dval  (link2_dval),
        .link2_data  (link2_data),
        .link2_rdreq (link2_rdreq),
        .cfg_valid   (cfg_valid),
        .cfg_data    (cfg_data),
        .dt_valid    (dt_valid),
        .dt_data     (dt_data)
    );

    // ------------------------------------------------
    // link queue models, answer one cycle after rdreq
    // ------------------------------------------------
    always @(posedge clk_100m) begin
        link1_dval <= 1'b0;
        // no request on an empty queue or with an answer due
        if (link1_rdreq && (link1_empty || link1_dval)) begin
            $display("link 1 read request while empty or awaiting an answer in %s",
                     test_name);
            protocol_count++;
        end
        if (link1_rdreq && link1_q.size() != 0) begin
            link1_dval <= 1'b1;
            link1_data <= link1_q.pop_front();
        end
        link1_empty <= (link1_q.size() == 0);
    end

    always @(posedge clk_100m) begin
        link2_dval <= 1'b0;
        if (link2_rdreq && (link2_empty || link2_dval)) begin
            $display("link 2 read request while empty or awaiting an answer in %s",
                     test_name);
            protocol_count++;
        end
        if (link2_rdreq && link2_q.size() != 0) begin
            link2_dval <= 1'b1;
            link2_data <= link2_q.pop_front();
        end
        link2_empty <= (link2_q.size() == 0);
    end

    // ------------------------------------------------
    // reference model of one frame in frame_words
    // ------------------------------------------------
    function automatic void predict_frame(input int len);
        logic [7:0]  src;
        logic [15:0] ftype;
        logic [9:0]  word;
        logic        released;
        int          pay_len;
        int          i;
        src     = frame_words[src_idx][7:0];
        ftype   = {frame_words[type_hi_idx][7:0], frame_words[type_lo_idx][7:0]};
        pay_len = len - hdr_len;
        // both status bytes written and zero
        released = (pay_len >= status_addr + 2) &&
                   (frame_words[hdr_len + status_addr][7:0] == 8'h00) &&
                   (frame_words[hdr_len + status_addr + 1][7:0] == 8'h00);
        if (src[src_bit] && pay_len > 0) begin
            for (i = 0; i < pay_len; i++) begin
                word = {i == 0, i == pay_len - 1, frame_words[hdr_len + i][7:0]};
                if (ftype == cfg_frame_type) begin
                    exp_cfg.push_back(word);
                end else if (ftype == data_frame_type && released) begin
                    exp_dt.push_back(word);
                end
            end
        end
    endfunction

    // build a frame with random bytes, push it to a link, predict it
    task automatic queue_frame(input int link, input logic [7:0] src,
                               input logic [15:0] ftype, input int pay_len,
                               input logic [7:0] status_hi,
                               input logic [7:0] status_lo);
        logic [7:0] b;
        int         i;
        frame_len = hdr_len + pay_len;
        for (i = 0; i < frame_len; i++) begin
            b = 8'($random(seed));
            if (i == src_idx) begin
                b = src;
            end else if (i == type_hi_idx) begin
                b = ftype[15:8];
            end else if (i == type_lo_idx) begin
                b = ftype[7:0];
            end else if (i == hdr_len + status_addr) begin
                b = status_hi;
            end else if (i == hdr_len + status_addr + 1) begin
                b = status_lo;
            end
            frame_words[i] = {i == 0, i == frame_len - 1, 8'h00, b};
        end
        // away from the edge where the models pop
        @(negedge clk_100m);
        for (i = 0; i < frame_len; i++) begin
            if (link == 1) begin
                link1_q.push_back(frame_words[i]);
            end else begin
                link2_q.push_back(frame_words[i]);
            end
        end
        loaded_words += frame_len;
        predict_frame(frame_len);
    endtask

    // all loaded words read and all expected words seen
    task automatic wait_drain();
        while (exp_cfg.size() != 0 || exp_dt.size() != 0 ||
               link1_q.size() != 0 || link2_q.size() != 0) begin
            @(negedge clk_100m);
        end
    endtask

    // ------------------------------------------------
    // compare on both output ports
    // ------------------------------------------------
    always @(posedge clk_100m) begin
        if (rst_100m) begin
            if (cfg_valid) begin
                if (exp_cfg.size() == 0) begin
                    $display("unexpected word %h on the configuration port in %s",
                             cfg_data, test_name);
                    unexpected_count++;
                end else begin
                    cfg_expect = exp_cfg.pop_front();
                    if (cfg_data !== cfg_expect) begin
                        $display("mismatch %s cfg_data expected %h actual %h",
                                 test_name, cfg_expect, cfg_data);
                        mismatch_count++;
                    end
                end
            end
            if (dt_valid) begin
                if (exp_dt.size() == 0) begin
                    $display("unexpected word %h on the data port in %s",
                             dt_data, test_name);
                    unexpected_count++;
                end else begin
                    dt_expect = exp_dt.pop_front();
                    if (dt_data !== dt_expect) begin
                        $display("mismatch %s dt_data expected %h actual %h",
                                 test_name, dt_expect, dt_data);
                        mismatch_count++;
                    end
                end
            end
        end
    end

    // ------------------------------------------------
    // watchdog, 200 cycles per loaded word
    // ------------------------------------------------
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 200 * loaded_words + 200) begin
            @(posedge clk_100m);
            cycles++;
        end
        $display("timeout in %s after %0d cycles, %0d cfg and %0d data words never came",
                 test_name, cycles, exp_cfg.size(), exp_dt.size());
        missing_count = exp_cfg.size() + exp_dt.size();
        $display("errors: %0d mismatch, %0d unexpected, %0d missing, %0d protocol",
                 mismatch_count, unexpected_count, missing_count, protocol_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ------------------------------------------------
    // test sequence
    // ------------------------------------------------
    initial begin : stimulus
        // two cfg frames per link before reset ends
        // grant alternates from link 1, so predict in that order
        test_name = "round robin";
        queue_frame(1, good_src, cfg_frame_type, 16, 8'h00, 8'h00);
        queue_frame(2, good_src, cfg_frame_type, 9, 8'h00, 8'h00);
        queue_frame(1, good_src, cfg_frame_type, 23, 8'h00, 8'h00);
        queue_frame(2, good_src, cfg_frame_type, 5, 8'h00, 8'h00);
        wait (rst_100m == 1'b1);
        wait_drain();

        // rejected frames, then a good one to show they passed
        test_name = "frame filter";
        queue_frame(1, bad_src, cfg_frame_type, 12, 8'h00, 8'h00);
        queue_frame(1, good_src, 16'h0E01, 12, 8'h00, 8'h00);
        queue_frame(1, bad_src, data_frame_type, 120, 8'h00, 8'h00);
        queue_frame(1, good_src, cfg_frame_type, 11, 8'h00, 8'h00);
        wait_drain();

        // either status byte nonzero held back, zero status released
        test_name = "data release";
        queue_frame(2, good_src, data_frame_type, 120, 8'h00, 8'h3C);
        queue_frame(2, good_src, data_frame_type, 120, 8'h5A, 8'h00);
        queue_frame(2, good_src, data_frame_type, 120, 8'h00, 8'h00);
        wait_drain();

        // buffer free again after done
        test_name = "buffer reuse";
        queue_frame(1, good_src, data_frame_type, 120, 8'h00, 8'h00);
        wait_drain();

        // quiet time to catch stray words
        test_name = "idle";
        repeat (100) @(posedge clk_100m);
        missing_count = exp_cfg.size() + exp_dt.size();
        $display("errors: %0d mismatch, %0d unexpected, %0d missing, %0d protocol",
                 mismatch_count, unexpected_count, missing_count, protocol_count);
        if (mismatch_count + unexpected_count + missing_count + protocol_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps
// ------------------------------------------------
// testbench clock of 10 ns and an active-low reset
// held for the first 10 rising edges
// ------------------------------------------------
module clock_gen (
    output logic clk_100m,
    output logic rst_100m
);
    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    // release on a rising edge, like all other stimulus
    initial begin
        rst_100m = 1'b0;
        repeat (10) @(posedge clk_100m);
        rst_100m <= 1'b1;
    end
endmodule

// File: source/rx_frame_top.sv
`timescale 1ns/1ps
// ------------------------------------------------
// receive path top: two link queues in, cfg stream
// and buffered data frames out on plain ports
// ------------------------------------------------
module rx_frame_top #(
    parameter int ADDR_WIDTH  = 10,
    parameter int STATUS_ADDR = 118
) (
    input  logic                                 clk_100m,
    input  logic                                 rst_100m,
    // link 1 receive queue
    input  logic                                 link1_empty,
    input  logic                                 link1_dval,
    input  logic [rx_frame_pkg::link_width-1:0]  link1_data,
    output logic                                 link1_rdreq,
    // link 2 receive queue
    input  logic                                 link2_empty,
    input  logic                                 link2_dval,
    input  logic [rx_frame_pkg::link_width-1:0]  link2_data,
    output logic                                 link2_rdreq,
    // configuration payload
    output logic                                 cfg_valid,
    output logic [9:0]                           cfg_data,
    // released data frames
    output logic                                 dt_valid,
    output logic [9:0]                           dt_data
);
    // merged link words, then data payload writes
    word_if arb_word ();
    word_if pay_word ();
    buf_rd_if #(.ADDR_WIDTH(ADDR_WIDTH)) buf_rd ();

    // producer side
    link_arbiter link_arbiter_inst (
        .clk_100m    (clk_100m),
        .rst_100m    (rst_100m),
        .link1_empty (link1_empty),
        .link1_dval  (link1_dval),
        .link1_data  (link1_data),
        .link1_rdreq (link1_rdreq),
        .link2_empty (link2_empty),
        .link2_dval  (link2_dval),
        .link2_data  (link2_data),
        .link2_rdreq (link2_rdreq),
        .word_out    (arb_word)
    );

    frame_classifier frame_classifier_inst (
        .clk_100m  (clk_100m),
        .rst_100m  (rst_100m),
        .word_in   (arb_word),
        .pay_out   (pay_word),
        .cfg_valid (cfg_valid),
        .cfg_data  (cfg_data)
    );

    frame_buffer #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .STATUS_ADDR (STATUS_ADDR)
    ) frame_buffer_inst (
        .clk_100m (clk_100m),
        .rst_100m (rst_100m),
        .pay_in   (pay_word),
        .rd_port  (buf_rd)
    );

    // consumer side
    frame_reader #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) frame_reader_inst (
        .clk_100m (clk_100m),
        .rst_100m (rst_100m),
        .rd_port  (buf_rd),
        .dt_valid (dt_valid),
        .dt_data  (dt_data)
    );

endmodule

// File: source/frame_reader.sv
`timescale 1ns/1ps
// ------------------------------------------------
// drains a released frame from the buffer onto the
// data port, one word per cycle up to the eop word
// ------------------------------------------------
module frame_reader #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                     clk_100m,
    input  logic                     rst_100m,
    buf_rd_if.rd                     rd_port,
    output logic                     dt_valid,
    output rx_frame_pkg::out_word_t  dt_data
);
    logic [ADDR_WIDTH-1:0] rd_addr;
    // rd_data holds a word addressed last cycle
    logic                  issued;
    // eop already sent, rest of the pipe is stale
    logic                  draining;
    logic                  done;
    logic                  take;

    assign take = issued && !draining;

    // ------------------------------------------------
    // address run and output register
    // ------------------------------------------------
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            rd_addr  <= '0;
            issued   <= 1'b0;
            draining <= 1'b0;
            done     <= 1'b0;
            dt_valid <= 1'b0;
        end else begin
            rd_addr <= rd_port.ready ? rd_addr + 1'b1 : '0;
            issued  <= rd_port.ready && !draining;
            // cleared once the buffer drops ready
            if (!rd_port.ready) begin
                draining <= 1'b0;
            end else if (take && rd_port.rd_data.eop) begin
                draining <= 1'b1;
            end
            done     <= take && rd_port.rd_data.eop;
            dt_valid <= take;
        end
    end

    always_ff @(posedge clk_100m) begin
        dt_data <= rd_port.rd_data;
    end

    assign rd_port.rd_addr = rd_addr;
    assign rd_port.done    = done;

endmodule

// File: source/frame_buffer.sv
`timescale 1ns/1ps
// ------------------------------------------------
// payload RAM for data frames; releases a frame to
// the reader once both status bytes are zero, and
// holds it until the reader strobes done
// ------------------------------------------------
module frame_buffer #(
    parameter int ADDR_WIDTH  = 10,
    parameter int STATUS_ADDR = 118
) (
    input  logic  clk_100m,
    input  logic  rst_100m,
    word_if.dst   pay_in,
    buf_rd_if.mem rd_port
);
    import rx_frame_pkg::*;

    localparam int depth = 2 ** ADDR_WIDTH;
    // status bytes sit at two fixed payload addresses
    localparam logic [ADDR_WIDTH-1:0] status_hi_addr = ADDR_WIDTH'(STATUS_ADDR);
    localparam logic [ADDR_WIDTH-1:0] status_lo_addr = ADDR_WIDTH'(STATUS_ADDR + 1);

    out_word_t             mem [depth];
    out_word_t             rd_data;
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic                  wr_active;
    logic                  wr_en;
    logic                  ready;
    byte_t                 status_hi;

    // sop restarts at address 0
    assign wr_addr = pay_in.sop ? '0 : wr_ptr;
    // a frame starting while one is held is dropped whole
    assign wr_en   = pay_in.valid && (pay_in.sop ? !ready : wr_active);

    // ------------------------------------------------
    // write side
    // ------------------------------------------------
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            wr_active <= 1'b0;
            wr_ptr    <= '0;
        end else begin
            if (pay_in.valid && pay_in.sop) begin
                wr_active <= !ready && !pay_in.eop;
            end else if (pay_in.valid && pay_in.eop) begin
                wr_active <= 1'b0;
            end
            if (wr_en) begin
                wr_ptr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (wr_en && wr_addr == status_hi_addr) begin
            status_hi <= pay_in.data;
        end
    end

    // release flag, done wins over a new release
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            ready <= 1'b0;
        end else if (rd_port.done) begin
            ready <= 1'b0;
        end else if (wr_en && wr_addr == status_lo_addr &&
                     pay_in.data == 8'h00 && status_hi == 8'h00) begin
            ready <= 1'b1;
        end
    end

    // inferred dual-port RAM, registered read
    always_ff @(posedge clk_100m) begin
        if (wr_en) begin
            mem[wr_addr] <= {pay_in.sop, pay_in.eop, pay_in.data};
        end
        rd_data <= mem[rd_port.rd_addr];
    end

    assign rd_port.ready   = ready;
    assign rd_port.rd_data = rd_data;

endmodule

// File: source/frame_classifier.sv
`timescale 1ns/1ps
// ------------------------------------------------
// frame header parser: picks source and type from
// the header, then routes the payload to the cfg
// port or to the frame buffer, or drops the frame
// ------------------------------------------------
module frame_classifier (
    input  logic                     clk_100m,
    input  logic                     rst_100m,
    word_if.dst                      word_in,
    word_if.src                      pay_out,
    output logic                     cfg_valid,
    output rx_frame_pkg::out_word_t  cfg_data
);
    import rx_frame_pkg::*;

    // counter only has to reach the payload index
    localparam int cnt_w = $clog2(payload_index + 1);

    cls_state_e       state;
    frame_kind_e      kind;
    logic [cnt_w-1:0] word_cnt;
    logic [cnt_w-1:0] word_idx;
    byte_t            src_addr;
    logic [15:0]      frame_type;
    logic             in_header;
    logic             at_payload;
    logic             cfg_fire;
    logic             data_fire;
    logic             pay_valid;
    logic             pay_sop;
    logic             pay_eop;
    byte_t            pay_data;

    // index of the current word, sop word is 0
    assign word_idx   = word_in.sop ? '0 : word_cnt;
    assign in_header  = word_in.valid && (state == cls_header);
    assign at_payload = in_header && (word_idx == cnt_w'(payload_index));

    // decision from the captured header fields
    always_comb begin
        kind = kind_none;
        if (src_addr[local_src_bit]) begin
            if (frame_type == cfg_type) begin
                kind = kind_cfg;
            end else if (frame_type == data_type) begin
                kind = kind_data;
            end
        end
    end

    assign cfg_fire  = word_in.valid &&
                       ((at_payload && kind == kind_cfg) || state == cls_cfg);
    assign data_fire = word_in.valid &&
                       ((at_payload && kind == kind_data) || state == cls_data);

    // header field capture
    always_ff @(posedge clk_100m) begin
        if (in_header) begin
            if (word_idx == cnt_w'(src_index)) begin
                src_addr <= word_in.data;
            end
            if (word_idx == cnt_w'(type_hi_index)) begin
                frame_type[15:8] <= word_in.data;
            end
            if (word_idx == cnt_w'(type_lo_index)) begin
                frame_type[7:0] <= word_in.data;
            end
        end
    end

    // ------------------------------------------------
    // word counter and routing fsm
    // ------------------------------------------------
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            state    <= cls_header;
            word_cnt <= '0;
        end else if (word_in.valid) begin
            case (state)
                cls_header: begin
                    word_cnt <= word_idx + 1'b1;
                    // single-word payload stays in header
                    if (at_payload && !word_in.eop) begin
                        case (kind)
                            kind_cfg:  state <= cls_cfg;
                            kind_data: state <= cls_data;
                            default:   state <= cls_skip;
                        endcase
                    end
                end
                default: begin
                    if (word_in.eop) begin
                        state <= cls_header;
                    end
                end
            endcase
        end
    end

    // output strobes, one cycle after the payload word
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            cfg_valid <= 1'b0;
            pay_valid <= 1'b0;
        end else begin
            cfg_valid <= cfg_fire;
            pay_valid <= data_fire;
        end
    end

    always_ff @(posedge clk_100m) begin
        cfg_data <= {at_payload, word_in.eop, word_in.data};
        pay_sop  <= at_payload;
        pay_eop  <= word_in.eop;
        pay_data <= word_in.data;
    end

    assign pay_out.valid = pay_valid;
    assign pay_out.sop   = pay_sop;
    assign pay_out.eop   = pay_eop;
    assign pay_out.data  = pay_data;

endmodule

// File: source/link_arbiter.sv
`timescale 1ns/1ps
// ------------------------------------------------
// round-robin reader of the two link receive queues
// a grant is held for a whole frame, words are
// registered onto the internal word stream
// ------------------------------------------------
module link_arbiter (
    input  logic                                 clk_100m,
    input  logic                                 rst_100m,
    input  logic                                 link1_empty,
    input  logic                                 link1_dval,
    input  logic [rx_frame_pkg::link_width-1:0]  link1_data,
    output logic                                 link1_rdreq,
    input  logic                                 link2_empty,
    input  logic                                 link2_dval,
    input  logic [rx_frame_pkg::link_width-1:0]  link2_data,
    output logic                                 link2_rdreq,
    word_if.src                                  word_out
);
    import rx_frame_pkg::*;

    arb_state_e            state;
    // 0 is link 1, 1 is link 2
    logic                  grant;
    // link that wins when both have data
    logic                  prefer;
    logic                  pick;
    logic                  sel_empty;
    logic                  sel_dval;
    logic [link_width-1:0] sel_data;
    logic                  out_valid;
    logic                  out_sop;
    logic                  out_eop;
    byte_t                 out_data;

    // mux of the granted link
    assign sel_empty = grant ? link2_empty : link1_empty;
    assign sel_dval  = grant ? link2_dval  : link1_dval;
    assign sel_data  = grant ? link2_data  : link1_data;

    // both waiting: alternate, else take the one with data
    assign pick = (!link1_empty && !link2_empty) ? prefer : link1_empty;

    // single-cycle request, only on a non-empty queue
    assign link1_rdreq = (state == arb_request) && !grant && !link1_empty;
    assign link2_rdreq = (state == arb_request) && grant && !link2_empty;

    // ------------------------------------------------
    // grant fsm
    // ------------------------------------------------
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            state  <= arb_idle;
            grant  <= 1'b0;
            prefer <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (!link1_empty || !link2_empty) begin
                        grant <= pick;
                        state <= arb_request;
                    end
                end
                // hold here across gaps inside a frame
                arb_request: begin
                    if (!sel_empty) begin
                        state <= arb_wait;
                    end
                end
                // answer comes one cycle after rdreq
                arb_wait: begin
                    if (sel_dval) begin
                        if (sel_data[eop_bit]) begin
                            prefer <= ~grant;
                            state  <= arb_idle;
                        end else begin
                            state <= arb_request;
                        end
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // stream strobe, one cycle after dval
    always_ff @(posedge clk_100m or negedge rst_100m) begin
        if (!rst_100m) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= (state == arb_wait) && sel_dval;
        end
    end

    always_ff @(posedge clk_100m) begin
        out_sop  <= sel_data[sop_bit];
        out_eop  <= sel_data[eop_bit];
        out_data <= sel_data[7:0];
    end

    assign word_out.valid = out_valid;
    assign word_out.sop   = out_sop;
    assign word_out.eop   = out_eop;
    assign word_out.data  = out_data;

endmodule

// File: source/rx_frame_ifs.sv
`timescale 1ns/1ps
// ------------------------------------------------
// internal interfaces: a strobed word stream with no
// back-pressure, and the read port of the frame buffer
// ------------------------------------------------

// one word per valid strobe
interface word_if;
    import rx_frame_pkg::*;

    logic  valid;
    logic  sop;
    logic  eop;
    byte_t data;

    modport src (
        output valid,
        output sop,
        output eop,
        output data
    );

    modport dst (
        input valid,
        input sop,
        input eop,
        input data
    );
endinterface

// buffer side holds ready until the reader strobes done
interface buf_rd_if #(
    parameter int ADDR_WIDTH = 10
);
    import rx_frame_pkg::*;

    logic                  ready;
    logic                  done;
    logic [ADDR_WIDTH-1:0] rd_addr;
    out_word_t             rd_data;

    modport mem (output ready, output rd_data, input done, input rd_addr);

    modport rd (input ready, input rd_data, output done, output rd_addr);
endinterface

// File: source/rx_frame_pkg.sv
// ------------------------------------------------
// shared widths, header offsets and frame types of
// the link receive path; modules import it in their
// body and use scoped names in their port lists
// ------------------------------------------------
package rx_frame_pkg;

    // link word layout
    localparam int link_width = 18;
    localparam int sop_bit    = 17;
    localparam int eop_bit    = 16;

    typedef logic [7:0] byte_t;

    // output word, sop and eop above the byte
    typedef struct packed {
        logic  sop;
        logic  eop;
        byte_t data;
    } out_word_t;

    // header word positions, counted from the sop word
    localparam int src_index     = 3;
    localparam int type_hi_index = 8;
    localparam int type_lo_index = 9;
    localparam int payload_index = 14;

    // frame accepted only with this source bit set
    localparam int local_src_bit = 2;

    localparam logic [15:0] cfg_type  = 16'h0C01;
    localparam logic [15:0] data_type = 16'h0D01;

    // routing decision for one frame
    typedef enum logic [1:0] {kind_none, kind_cfg, kind_data} frame_kind_e;

    typedef enum logic [1:0] {arb_idle, arb_request, arb_wait} arb_state_e;

    typedef enum logic [1:0] {cls_header, cls_cfg, cls_data, cls_skip} cls_state_e;

endpackage
